/* Bender.yml */
package:
  name: cnn_accel

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/cnn_pkgs.sv
      - hdl/patch_load_if.sv
      - hdl/conv_sequencer.sv
      - hdl/kernel_loader.sv
      - hdl/patch_buffer.sv
      - hdl/conv_pool_unit.sv
      - hdl/pool_packer.sv
      - hdl/scratch_write_arbiter.sv
      - hdl/cnn_accel_top.sv
  - target: test
    files:
      - dv/cnn_accel_sva.sv
      - dv/cnn_accel_tb.sv

/* cnn_accel.f */
+incdir+hdl
hdl/cnn_pkgs.sv
hdl/patch_load_if.sv
hdl/conv_sequencer.sv
hdl/kernel_loader.sv
hdl/patch_buffer.sv
hdl/conv_pool_unit.sv
hdl/pool_packer.sv
hdl/scratch_write_arbiter.sv
hdl/cnn_accel_top.sv
dv/cnn_accel_sva.sv
dv/cnn_accel_tb.sv

/* dv/cnn_accel_sva.sv */
`default_nettype none

module cnn_accel_sva (
  input logic               clk,
  input logic               convolution_reset,
  input logic               dut_busy,
  input logic               scratchpad_sram_write_enable,
  input cnn_mem_pkg::addr_t scratchpad_sram_write_address
);

  cnn_mem_pkg::addr_t last_addr;  // address of the previous write
  logic               wrote;      // a write has happened in this run

  always_ff @(posedge clk) begin
    if (!convolution_reset || !dut_busy) begin
      wrote <= 1'b0;
    end else if (scratchpad_sram_write_enable) begin
      wrote     <= 1'b1;
      last_addr <= scratchpad_sram_write_address;
    end
  end

  // consecutive writes of a run use consecutive addresses
  write_address_steps: assert property (
    @(posedge clk) disable iff (!convolution_reset)
    scratchpad_sram_write_enable && wrote |->
      scratchpad_sram_write_address == last_addr + 1'b1
  ) else $error("scratchpad write address did not advance by one");

  write_only_when_busy: assert property (
    @(posedge clk) disable iff (!convolution_reset)
    scratchpad_sram_write_enable |-> dut_busy
  ) else $error("scratchpad write while dut_busy is low");

  busy_low_in_reset: assert property (
    @(posedge clk) !convolution_reset |=> !dut_busy
  ) else $error("dut_busy high during reset");

endmodule

bind cnn_accel_top cnn_accel_sva i_cnn_accel_sva (.*);

`default_nettype wire

/* dv/cnn_accel_tb.sv */
`default_nettype none

`include "cnn_accel_settings.svh"

module cnn_accel_tb;
  import cnn_mem_pkg::*;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 4;
  localparam int RUN_OVERHEAD = 40;  // kernel load, terminator and drain

  logic  clk;
  logic  convolution_reset;
  logic  dut_run;
  logic  dut_busy;
  addr_t input_sram_read_address;
  word_t input_sram_read_data;
  addr_t weights_sram_read_address;
  word_t weights_sram_read_data;
  logic  scratchpad_sram_write_enable;
  addr_t scratchpad_sram_write_address;
  word_t scratchpad_sram_write_data;

  word_t       input_mem [0:(1 << `ADDR_W) - 1];
  word_t       weights_mem [0:`KERNEL_WORDS - 1];
  int          kern_w [0:8];  // signed weights, row major
  addr_t       wr_addr [$];   // scratchpad writes in order
  word_t       wr_data [$];
  word_t       expected [$];
  int          run_budget;
  logic [31:0] rng_state;
  int          checks;
  int          errors;

  cnn_accel_top i_cnn_accel_top (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // sram models, one cycle read latency
  always @(posedge clk) begin
    input_sram_read_data   <= input_mem[input_sram_read_address];
    weights_sram_read_data <= weights_mem[weights_sram_read_address];
    if (scratchpad_sram_write_enable) begin
      wr_addr.push_back(scratchpad_sram_write_address);
      wr_data.push_back(scratchpad_sram_write_data);
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic word_t random_word();
    rng_state = xorshift(rng_state);
    return rng_state[15:0];
  endfunction

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] t=%0t %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // mode 0 random, 1 non-negative, 2 all 127
  task automatic load_image(input int base, input int n, input int mode, output int next_base);
    word_t w;
    input_mem[base] = word_t'(n);
    for (int a = 1; a <= n * n / 2; a++) begin
      w = random_word();
      if (mode == 1) w = w & 16'h7f7f;
      if (mode == 2) w = 16'h7f7f;
      input_mem[base + a] = w;
    end
    next_base = base + 1 + n * n / 2;
    input_mem[next_base] = `END_MARKER;  // overwritten by a following image
  endtask

  task automatic load_kernel();
    logic [7:0] b [0:9];
    for (int t = 0; t < 9; t++) b[t] = kern_w[t][7:0];
    b[9] = 8'h5a;  // unused byte
    for (int w = 0; w < `KERNEL_WORDS; w++) weights_mem[w] = {b[2 * w], b[2 * w + 1]};
  endtask

  // ----------------------------------------------------------------------
  // reference model, read back from the input memory
  function automatic int pixel_at(input int base, input int n, input int r, input int c);
    word_t w;
    w = input_mem[base + 1 + r * (n / 2) + c / 2];
    return (c % 2 == 0) ? $signed(w[15:8]) : $signed(w[7:0]);
  endfunction

  function automatic int pool_window(input int base, input int n, input int i, input int j);
    int best;
    int sum;
    best = -(1 << 30);
    for (int a = 0; a < 2; a++) begin
      for (int b = 0; b < 2; b++) begin
        sum = 0;
        for (int u = 0; u < 3; u++) begin
          for (int v = 0; v < 3; v++) begin
            sum += kern_w[3 * u + v] * pixel_at(base, n, 2 * i + a + u, 2 * j + b + v);
          end
        end
        if (sum > best) best = sum;
      end
    end
    if (best < 0) return 0;
    if (best > `RELU_MAX) return `RELU_MAX;
    return best;
  endfunction

  function automatic int image_cycles(input int n);
    int p;
    p = (n - 2) / 2;
    return 8 * p * p + 16;  // eight reads per window plus header
  endfunction

  task automatic build_expected();
    int base;
    int n;
    int p;
    int hi;
    int lo;
    expected.delete();
    base = 0;
    run_budget = RUN_OVERHEAD;
    while (input_mem[base] !== `END_MARKER) begin
      n = input_mem[base][7:0];
      p = (n - 2) / 2;
      expected.push_back(word_t'(p));
      for (int i = 0; i < p; i++) begin
        for (int j = 0; j < p; j++) begin
          if ((i * p + j) % 2 == 0) begin
            hi = pool_window(base, n, i, j);
          end else begin
            lo = pool_window(base, n, i, j);
            expected.push_back({hi[7:0], lo[7:0]});  // first byte high
          end
        end
      end
      run_budget += image_cycles(n);
      base += 1 + n * n / 2;
    end
  endtask

  task automatic run_and_check(input string name);
    int cycles;
    build_expected();
    wr_addr.delete();
    wr_data.delete();
    @(negedge clk);
    dut_run = 1'b1;
    @(negedge clk);
    dut_run = 1'b0;
    check_value($sformatf("%s busy after start", name), dut_busy, 1);
    cycles = 0;
    while (dut_busy === 1'b1 && cycles < run_budget) begin
      @(negedge clk);
      cycles++;
    end
    if (dut_busy !== 1'b0) begin
      errors++;
      $display("%s: dut_busy did not fall within %0d cycles", name, run_budget);
    end
    check_value($sformatf("%s write count", name), wr_data.size(), expected.size());
    for (int w = 0; w < wr_data.size() && w < expected.size(); w++) begin
      check_value($sformatf("%s address of write %0d", name, w), wr_addr[w], w);
      check_value($sformatf("%s word %0d", name, w), wr_data[w], expected[w]);
    end
  endtask

  task automatic report_test(input string name, input int start_errors);
    $display("%s finished, %0d new errors", name, errors - start_errors);
  endtask

  // ----------------------------------------------------------------------
  // directed tests
  task automatic reset_behaviour();
    int e0;
    e0 = errors;
    check_value("busy after reset", dut_busy, 0);
    check_value("write enable after reset", scratchpad_sram_write_enable, 0);
    load_kernel();
    input_mem[0] = `END_MARKER;
    run_and_check("terminator only");
    report_test("reset behaviour", e0);
  endtask

  task automatic centre_kernel();
    int e0;
    int nb;
    e0 = errors;
    for (int t = 0; t < 9; t++) kern_w[t] = (t == 4) ? 1 : 0;
    load_kernel();
    load_image(0, 6, 0, nb);
    run_and_check("centre kernel");
    if (wr_data.size() > 0) check_value("centre header", wr_data[0], 2);
    report_test("centre kernel", e0);
  endtask

  task automatic relu_floor();
    int e0;
    int nb;
    e0 = errors;
    for (int t = 0; t < 9; t++) kern_w[t] = -(1 + t % 3);
    load_kernel();
    load_image(0, 6, 1, nb);
    run_and_check("relu");
    for (int w = 1; w < wr_data.size(); w++) check_value("relu byte pair", wr_data[w], 0);
    report_test("relu", e0);
  endtask

  task automatic saturation();
    int e0;
    int nb;
    e0 = errors;
    for (int t = 0; t < 9; t++) kern_w[t] = 127;
    load_kernel();
    load_image(0, 6, 2, nb);
    run_and_check("saturation");
    for (int w = 1; w < wr_data.size(); w++) check_value("saturated pair", wr_data[w], 16'h7f7f);
    report_test("saturation", e0);
  endtask

  task automatic back_to_back_images();
    int e0;
    int nb;
    word_t w;
    e0 = errors;
    for (int t = 0; t < 9; t++) begin
      w = random_word();
      kern_w[t] = $signed(w[7:0]);
    end
    load_kernel();
    load_image(0, 6, 0, nb);
    load_image(nb, 10, 0, nb);
    run_and_check("back to back");
    report_test("back to back", e0);
  endtask

  task automatic second_run();
    int e0;
    int nb;
    e0 = errors;
    load_image(0, 10, 0, nb);
    run_and_check("first of two runs");
    load_image(0, 6, 0, nb);
    run_and_check("second run");  // addresses checked from 0 again
    report_test("second run", e0);
  endtask

  initial begin
    rng_state = 32'he923;
    checks = 0;
    errors = 0;
    convolution_reset = 1'b0;
    dut_run = 1'b0;
    input_sram_read_data = '0;
    weights_sram_read_data = '0;
    for (int t = 0; t < 9; t++) kern_w[t] = 0;
    repeat (RESET_CYCLES) @(negedge clk);
    convolution_reset = 1'b1;
    @(negedge clk);
    reset_behaviour();
    centre_kernel();
    relu_floor();
    saturation();
    back_to_back_images();
    second_run();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // seven runs, five 6x6 and two 10x10 images, doubled for margin
  initial begin : watchdog
    int limit;
    limit = RESET_CYCLES + 7 * RUN_OVERHEAD + 5 * image_cycles(6) + 2 * image_cycles(10);
    #(2 * limit * CLK_PERIOD);
    $display("watchdog expired before the tests completed");
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/cnn_accel_settings.svh */
`ifndef CNN_ACCEL_SETTINGS_SVH
`define CNN_ACCEL_SETTINGS_SVH

// sram geometry
`define ADDR_W 12
`define WORD_W 16

// datapath widths
`define PIX_W 8
`define ACC_W 20  // nine 16-bit products with headroom

// kernel is nine bytes spread over five words
`define KERNEL_WORDS 5

`define RELU_MAX 127
`define END_MARKER {`WORD_W{1'b1}}  // terminator in place of a header
`define DRAIN_CYCLES 4

`endif

/* hdl/cnn_accel_top.sv */
`default_nettype none

module cnn_accel_top (
  input  logic               clk,
  input  logic               convolution_reset,
  input  logic               dut_run,
  output logic               dut_busy,
  output cnn_mem_pkg::addr_t input_sram_read_address,
  input  cnn_mem_pkg::word_t input_sram_read_data,
  output cnn_mem_pkg::addr_t weights_sram_read_address,
  input  cnn_mem_pkg::word_t weights_sram_read_data,
  output logic               scratchpad_sram_write_enable,
  output cnn_mem_pkg::addr_t scratchpad_sram_write_address,
  output cnn_mem_pkg::word_t scratchpad_sram_write_data
);
  import cnn_data_pkg::*;
  import cnn_mem_pkg::*;

  // ----------------------------------------------------------------------
  // internal nets, named after the ports they join
  logic    kernel_start;
  logic    kernel_ready;
  logic    run_start;
  logic    hdr_req;
  logic    hdr_gnt;
  word_t   hdr_word;
  kernel_t kernel;
  patch_t  patch;
  logic    patch_valid;
  pixel_t  pooled;
  logic    pooled_valid;
  logic    data_req;
  logic    data_gnt;
  word_t   data_word;

  patch_load_if ld ();

  conv_sequencer        i_conv_sequencer        (.*);
  kernel_loader         i_kernel_loader         (.*);
  patch_buffer          i_patch_buffer          (.*);
  conv_pool_unit        i_conv_pool_unit        (.*);
  pool_packer           i_pool_packer           (.*);
  scratch_write_arbiter i_scratch_write_arbiter (.*);

endmodule

`default_nettype wire

/* hdl/cnn_pkgs.sv */
`default_nettype none

`include "cnn_accel_settings.svh"

// ----------------------------------------------------------------------
// datapath side
package cnn_data_pkg;
  typedef logic signed [`PIX_W-1:0] pixel_t;
  typedef logic signed [`PIX_W-1:0] weight_t;
  typedef weight_t [0:8] kernel_t;     // row major, k[3*row+col]
  typedef pixel_t [0:3][0:3] patch_t;  // [row][col]
  typedef logic signed [`ACC_W-1:0] acc_t;
endpackage

// ----------------------------------------------------------------------
// memory side
package cnn_mem_pkg;
  typedef logic [`ADDR_W-1:0] addr_t;
  typedef logic [`WORD_W-1:0] word_t;
  // N from the header, or P for the scratchpad
  typedef logic [7:0] img_size_t;
endpackage

`default_nettype wire

/* hdl/conv_pool_unit.sv */
`default_nettype none

`include "cnn_accel_settings.svh"

module conv_pool_unit (
  input  logic                  clk,
  input  logic                  convolution_reset,
  input  cnn_data_pkg::kernel_t kernel,
  input  cnn_data_pkg::patch_t  patch,
  input  logic                  patch_valid,
  output cnn_data_pkg::pixel_t  pooled,
  output logic                  pooled_valid
);
  import cnn_data_pkg::*;

  acc_t   sums [0:3];  // conv outputs at (0,0) (0,1) (1,0) (1,1)
  logic   s1_valid;
  acc_t   best;
  pixel_t clamped;

  // valid 3x3 conv anchored at patch (row, col)
  function automatic acc_t conv3x3(kernel_t kern, patch_t pat, int row, int col);
    acc_t sum;
    sum = '0;
    for (int u = 0; u < 3; u++) begin
      for (int v = 0; v < 3; v++) begin
        sum = sum + acc_t'($signed(kern[3*u+v])) * acc_t'($signed(pat[row+u][col+v]));
      end
    end
    return sum;
  endfunction

  // ----------------------------------------------------------------------
  // stage one, the four convolutions
  always_ff @(posedge clk) begin
    if (patch_valid) begin
      for (int q = 0; q < 4; q++) begin
        sums[q] <= conv3x3(kernel, patch, q / 2, q % 2);
      end
    end
  end

  // ----------------------------------------------------------------------
  // stage two, 2x2 max then relu with saturation
  always_comb begin
    best = sums[0];
    for (int q = 1; q < 4; q++) begin
      if (sums[q] > best) best = sums[q];
    end
    if (best < 0) clamped = '0;
    else if (best > `RELU_MAX) clamped = pixel_t'(`RELU_MAX);
    else clamped = pixel_t'(best[`PIX_W-1:0]);
  end

  always_ff @(posedge clk) begin
    if (s1_valid) pooled <= clamped;
  end

  always_ff @(posedge clk) begin
    if (!convolution_reset) begin
      s1_valid     <= 1'b0;
      pooled_valid <= 1'b0;
    end else begin
      s1_valid     <= patch_valid;
      pooled_valid <= s1_valid;
    end
  end

endmodule

`default_nettype wire

/* hdl/conv_sequencer.sv */
`default_nettype none

`include "cnn_accel_settings.svh"

module conv_sequencer (
  input  logic                clk,
  input  logic                convolution_reset,
  input  logic                dut_run,
  input  cnn_mem_pkg::word_t  input_sram_read_data,
  input  logic                kernel_ready,
  output logic                dut_busy,
  output cnn_mem_pkg::addr_t  input_sram_read_address,
  output logic                kernel_start,
  output logic                run_start,
  output logic                hdr_req,
  output cnn_mem_pkg::word_t  hdr_word,
  input  logic                hdr_gnt,
  patch_load_if.seq           ld
);
  import cnn_mem_pkg::*;

  localparam int DRAIN_W = $clog2(`DRAIN_CYCLES + 1);

  typedef enum logic [2:0] {S_IDLE, S_KERNEL, S_HEADER, S_FETCH, S_DRAIN} state_t;

  state_t             state;
  logic               start_pulse;
  addr_t              base;      // header address of the current image
  addr_t              row_base;  // first word of input row 2i
  img_size_t          n;
  img_size_t          p_size;
  img_size_t          p_last;
  img_size_t          pi;
  img_size_t          pj;
  logic [2:0]         k;         // read within the patch, {row, half}
  logic [1:0]         hdr_cnt;
  logic [DRAIN_W-1:0] drain_cnt;
  addr_t              half_n;
  addr_t              row_off;
  addr_t              fetch_addr;

  assign kernel_start = start_pulse;
  assign run_start    = start_pulse;

  assign p_size   = (n >> 1) - 8'd1;  // P = (N-2)/2
  assign p_last   = p_size - 8'd1;
  assign hdr_word = word_t'(p_size);
  assign half_n   = addr_t'(n >> 1);

  always_comb begin
    case (k[2:1])
      2'd0:    row_off = '0;
      2'd1:    row_off = half_n;
      2'd2:    row_off = addr_t'(n);
      default: row_off = addr_t'(n) + half_n;
    endcase
  end

  assign fetch_addr = row_base + row_off + addr_t'(pj) + addr_t'(k[0]);
  assign input_sram_read_address = (state == S_FETCH) ? fetch_addr : base;

  // ----------------------------------------------------------------------
  // run control
  always_ff @(posedge clk) begin
    if (!convolution_reset) begin
      state       <= S_IDLE;
      dut_busy    <= 1'b0;
      start_pulse <= 1'b0;
      hdr_req     <= 1'b0;
      base        <= '0;
      row_base    <= '0;
      n           <= '0;
      pi          <= '0;
      pj          <= '0;
      k           <= '0;
      hdr_cnt     <= '0;
      drain_cnt   <= '0;
    end else begin
      start_pulse <= 1'b0;
      if (hdr_gnt) hdr_req <= 1'b0;
      case (state)
        S_IDLE: begin
          if (dut_run) begin
            state       <= S_KERNEL;
            dut_busy    <= 1'b1;
            start_pulse <= 1'b1;
            base        <= '0;
          end
        end
        S_KERNEL: begin
          if (kernel_ready) begin
            state   <= S_HEADER;
            hdr_cnt <= '0;
          end
        end
        S_HEADER: begin
          // header is judged late so its write follows the last word
          // of the previous image out of the conv pipeline
          hdr_cnt <= hdr_cnt + 2'd1;
          if (hdr_cnt == 2'd3) begin
            if (input_sram_read_data == `END_MARKER) begin
              state     <= S_DRAIN;
              drain_cnt <= DRAIN_W'(`DRAIN_CYCLES - 1);
            end else begin
              state    <= S_FETCH;
              n        <= input_sram_read_data[7:0];
              hdr_req  <= 1'b1;
              row_base <= base + 1'b1;
              pi       <= '0;
              pj       <= '0;
              k        <= '0;
            end
          end
        end
        S_FETCH: begin
          k <= k + 3'd1;
          if (k == 3'd7) begin  // window complete
            if (pj == p_last) begin
              pj       <= '0;
              row_base <= row_base + addr_t'(n);
              if (pi == p_last) begin
                state   <= S_HEADER;
                hdr_cnt <= '0;
                base    <= row_base + (addr_t'(n) << 1);  // skip last four rows
              end else begin
                pi <= pi + 8'd1;
              end
            end else begin
              pj <= pj + 8'd1;
            end
          end
        end
        S_DRAIN: begin
          if (drain_cnt == DRAIN_W'(1)) begin
            state    <= S_IDLE;
            dut_busy <= 1'b0;
          end else begin
            drain_cnt <= drain_cnt - 1'b1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // patch steering, one cycle behind the address
  always_ff @(posedge clk) begin
    if (!convolution_reset) begin
      ld.word_valid <= 1'b0;
      ld.patch_done <= 1'b0;
    end else begin
      ld.word_valid <= (state == S_FETCH);
      ld.patch_done <= (state == S_FETCH) && (k == 3'd7);
    end
  end

  always_ff @(posedge clk) begin
    ld.word_row  <= k[2:1];
    ld.word_half <= k[0];
  end

endmodule

`default_nettype wire

/* hdl/kernel_loader.sv */
`default_nettype none

`include "cnn_accel_settings.svh"

module kernel_loader (
  input  logic                  clk,
  input  logic                  convolution_reset,
  input  logic                  kernel_start,
  input  cnn_mem_pkg::word_t    weights_sram_read_data,
  output cnn_mem_pkg::addr_t    weights_sram_read_address,
  output cnn_data_pkg::kernel_t kernel,
  output logic                  kernel_ready
);

  logic rd_active;
  logic data_valid;  // weights data bus holds a requested word
  logic data_last;

  always_ff @(posedge clk) begin
    if (!convolution_reset) begin
      rd_active                 <= 1'b0;
      data_valid                <= 1'b0;
      data_last                 <= 1'b0;
      kernel_ready              <= 1'b0;
      weights_sram_read_address <= '0;
    end else begin
      data_valid   <= rd_active;
      data_last    <= rd_active &&
                      (weights_sram_read_address == `ADDR_W'(`KERNEL_WORDS - 1));
      kernel_ready <= data_valid && data_last;
      if (kernel_start) begin
        rd_active                 <= 1'b1;
        weights_sram_read_address <= '0;
      end else if (rd_active) begin
        weights_sram_read_address <= weights_sram_read_address + 1'b1;
        if (weights_sram_read_address == `ADDR_W'(`KERNEL_WORDS - 1)) rd_active <= 1'b0;
      end
    end
  end

  // two weights per word, last word carries only one
  always_ff @(posedge clk) begin
    if (data_valid) begin
      if (data_last) begin
        kernel <= {kernel[1:8], weights_sram_read_data[`WORD_W-1 -: `PIX_W]};
      end else begin
        kernel <= {kernel[2:8], weights_sram_read_data};
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/patch_buffer.sv */
`default_nettype none

`include "cnn_accel_settings.svh"

module patch_buffer (
  input  logic                 clk,
  input  logic                 convolution_reset,
  input  cnn_mem_pkg::word_t   input_sram_read_data,
  patch_load_if.buffer         ld,
  output cnn_data_pkg::patch_t patch,
  output logic                 patch_valid
);

  // high byte is the left pixel of the pair
  always_ff @(posedge clk) begin
    if (ld.word_valid) begin
      patch[ld.word_row][{ld.word_half, 1'b0}] <= input_sram_read_data[`WORD_W-1 -: `PIX_W];
      patch[ld.word_row][{ld.word_half, 1'b1}] <= input_sram_read_data[`PIX_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!convolution_reset) begin
      patch_valid <= 1'b0;
    end else begin
      patch_valid <= ld.patch_done;  // last word lands with patch_done
    end
  end

endmodule

`default_nettype wire

/* hdl/patch_load_if.sv */
`default_nettype none

// steering for words returned from the input sram
interface patch_load_if;
  logic       word_valid;  // data on the sram bus belongs to the patch
  logic [1:0] word_row;    // patch row 0..3
  logic       word_half;   // left or right pixel pair
  logic       patch_done;  // with the eighth word

  modport seq (
    output word_valid, word_row, word_half, patch_done
  );
  modport buffer (
    input word_valid, word_row, word_half, patch_done
  );
endinterface

`default_nettype wire

/* hdl/pool_packer.sv */
`default_nettype none

module pool_packer (
  input  logic                 clk,
  input  logic                 convolution_reset,
  input  cnn_data_pkg::pixel_t pooled,
  input  logic                 pooled_valid,
  output logic                 data_req,
  output cnn_mem_pkg::word_t   data_word,
  input  logic                 data_gnt
);
  import cnn_data_pkg::*;

  pixel_t hi_byte;
  logic   have_hi;  // first byte of a pair is waiting

  always_ff @(posedge clk) begin
    if (!convolution_reset) begin
      have_hi  <= 1'b0;
      data_req <= 1'b0;
    end else begin
      if (data_gnt) data_req <= 1'b0;
      if (pooled_valid) begin
        have_hi <= !have_hi;
        if (have_hi) data_req <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pooled_valid) begin
      if (!have_hi) hi_byte <= pooled;
      else data_word <= {hi_byte, pooled};  // high byte first
    end
  end

endmodule

`default_nettype wire

/* hdl/scratch_write_arbiter.sv */
`default_nettype none

module scratch_write_arbiter (
  input  logic               clk,
  input  logic               convolution_reset,
  input  logic               run_start,
  input  logic               hdr_req,
  input  cnn_mem_pkg::word_t hdr_word,
  input  logic               data_req,
  input  cnn_mem_pkg::word_t data_word,
  output logic               hdr_gnt,
  output logic               data_gnt,
  output logic               scratchpad_sram_write_enable,
  output cnn_mem_pkg::addr_t scratchpad_sram_write_address,
  output cnn_mem_pkg::word_t scratchpad_sram_write_data
);

  // packer wins, a header simply waits a cycle
  assign data_gnt = data_req;
  assign hdr_gnt  = hdr_req && !data_req;

  assign scratchpad_sram_write_enable = data_req || hdr_req;
  assign scratchpad_sram_write_data   = data_req ? data_word : hdr_word;

  always_ff @(posedge clk) begin
    if (!convolution_reset) begin
      scratchpad_sram_write_address <= '0;
    end else if (run_start) begin
      scratchpad_sram_write_address <= '0;
    end else if (scratchpad_sram_write_enable) begin
      scratchpad_sram_write_address <= scratchpad_sram_write_address + 1'b1;
    end
  end

endmodule

`default_nettype wire
